//--- flist.f
rtl/rsched_lane_pkg.sv
rtl/rsched_csr_pkg.sv
rtl/rsched_fifo.sv
rtl/rsched_regroup.sv
rtl/rsched_csr.sv
rtl/rsched_top.sv
verif/rsched_clkgen.sv
verif/rsched_props.sv
verif/rsched_tb.sv

//--- Makefile
# Verilator build and run for the read regroup scheduler

TOP := rsched_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

//--- verif/rsched_trace.txt
# op a b c in hex: T test start, E test end, D wait until the expected groups have left
# W addr data, R addr expected, G read GROUPS against the model, X addr read expecting pslverr
# P num_valid eop [count] push words, O num_valid eop push a word the full FIFO must drop
T 1
W 0 81
P 8 0 2
P 5 0
P 3 0
D
E
T 2
P 8 3
P 6 0
P 4 2
P 7 7
D
E
T 3
W 0 01
R 0 11
W 0 41
R 0 41
P 8 3
P 6 0
P 4 2
P 7 7
D
E
T 4
W 0 80
P 8 0 8
P 5 0
P 3 0
P 8 2
P 2 0
P 7 4
P 5 0
P 8 0
P 8 8
O 8 0
R 4 1001
W 4 1
R 4 1000
W 0 81
D
R 4 0
E
T 5
G
W 8 5a5a
G
P 8 0
D
G
E
T 6
X c
R 0 81
R 4 0
G
E

//--- verif/rsched_tb.sv
////////////////////////////////////////////////////////////
// testbench for the read regroup scheduler
// replays the trace file and checks groups against a lane model
////////////////////////////////////////////////////////////

module rsched_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rsched_lane_pkg::*;
	import rsched_csr_pkg::*;

	logic       clk_rd;
	logic       aclr_rd;
	lane_word_t wr_word;
	logic       wr_overflow;
	lane_cnt_t  rd_num_valid;
	apb_req_t   apb_req;
	apb_rsp_t   apb_rsp;

	// trace lines and the group sizes the model still expects, oldest first
	string     lines[$];
	lane_cnt_t exp_groups[$];

	// lane model state, follows the accept and emit rules of the scheduler
	int pend;
	int owed;
	int gmax;
	int model_groups;

	// run bookkeeping
	int limit;
	int cycles;
	int checks;
	int errors;
	int tests;
	int test_id;
	int test_errs;
	int ovf_seen;
	int ovf_exp;

	rsched_clkgen i_clkgen (
		.clk_rd  (clk_rd),
		.aclr_rd (aclr_rd)
	);

	rsched_top #(
		.FIFO_DEPTH (16)
	) i_rsched_top (
		.clk_rd       (clk_rd),
		.aclr_rd      (aclr_rd),
		.wr_word      (wr_word),
		.wr_overflow  (wr_overflow),
		.rd_num_valid (rd_num_valid),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp)
	);

	bind rsched_top rsched_props i_props (
		.clk_rd       (clk_rd),
		.aclr_rd      (aclr_rd),
		.wr_overflow  (wr_overflow),
		.rd_num_valid (rd_num_valid),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp)
	);

	////////////////////////////////////////////////////////////
	// error counting and compare tasks
	////////////////////////////////////////////////////////////

	task automatic note_error(input string text);
		$display("%s", text);
		errors++;
		test_errs++;
	endtask

	task automatic compare_group(input lane_cnt_t got, input lane_cnt_t exp);
		checks++;
		if (got !== exp) begin
			note_error($sformatf("mismatch at %0d ns: group of %0d lanes, expected %0d",
				$time, got, exp));
		end
	endtask

	task automatic compare_reg(input logic [31:0] got, input logic [31:0] exp,
		input logic [3:0] addr);
		checks++;
		if (got !== exp) begin
			note_error($sformatf("mismatch at %0d ns: register 0x%h read 0x%h, expected 0x%h",
				$time, addr, got, exp));
		end
	endtask

	// only the handshake fields are judged, read data goes through compare_reg
	task automatic compare_resp(input apb_rsp_t got, input apb_rsp_t exp);
		checks++;
		if (got.pready !== exp.pready || got.pslverr !== exp.pslverr) begin
			note_error($sformatf("mismatch at %0d ns: pready %b pslverr %b, expected %b %b",
				$time, got.pready, got.pslverr, exp.pready, exp.pslverr));
		end
	endtask

	////////////////////////////////////////////////////////////
	// lane model
	////////////////////////////////////////////////////////////

	// flush lanes leave first, then full groups, until nothing more can go
	task automatic model_emit();
		int grp;
		while (owed > 0 || pend >= gmax) begin
			if (owed > 0) begin
				grp = (owed < gmax) ? owed : gmax;
				owed -= grp;
			end else begin
				grp = gmax;
				pend -= gmax;
			end
			exp_groups.push_back(lane_cnt_t'(grp));
			model_groups++;
		end
	endtask

	task automatic model_accept(input int nv, input int eop);
		if (eop != 0) begin
			owed = pend + eop;
			pend = nv - eop;
		end else begin
			pend += nv;
		end
		model_emit();
	endtask

	task automatic model_write(input logic [3:0] addr, input logic [31:0] data);
		if (addr == ADDR_CTRL) begin
			// a group size of 0 becomes 1 and anything past a word becomes 8
			gmax = int'(data[7:4]);
			if (gmax == 0) begin
				gmax = 1;
			end else if (gmax > 8) begin
				gmax = 8;
			end
			model_emit();
		end else if (addr == ADDR_GROUPS) begin
			model_groups = 0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// drivers
	////////////////////////////////////////////////////////////

	// setup phase, access phase, then idle, response taken mid access phase
	task automatic apb_access(input logic wr, input logic [3:0] addr,
		input logic [31:0] data, output apb_rsp_t rsp);
		@(posedge clk_rd);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
		@(posedge clk_rd);
		#1;
		apb_req.penable = 1'b1;
		@(negedge clk_rd);
		rsp = apb_rsp;
		@(posedge clk_rd);
		#1;
		apb_req = '0;
	endtask

	// one word for one cycle followed by an idle cycle
	task automatic drive_word(input int nv, input int eop);
		@(posedge clk_rd);
		#1;
		wr_word.num_valid    = lane_cnt_t'(nv);
		wr_word.eop_position = lane_cnt_t'(eop);
		@(posedge clk_rd);
		#1;
		wr_word = '0;
	endtask

	task automatic wait_drain();
		while (exp_groups.size() != 0) begin
			@(posedge clk_rd);
		end
		repeat (4) @(posedge clk_rd);
	endtask

	////////////////////////////////////////////////////////////
	// trace handling
	////////////////////////////////////////////////////////////

	task automatic load_trace(output bit ok);
		int    fd;
		string line;
		fd = $fopen("verif/rsched_trace.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0 && line.len() > 0) begin
					if (line.getc(0) != "#" && line.getc(0) != "\n") begin
						lines.push_back(line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_line(input string line);
		byte         op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		apb_rsp_t    rsp;
		apb_rsp_t    ok_rsp;
		apb_rsp_t    err_rsp;
		a = '0;
		b = '0;
		c = 32'd1;
		op = line.getc(0);
		void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
		ok_rsp  = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
		err_rsp = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
		case (op)
			"T": begin
				test_id   = int'(a);
				test_errs = 0;
				ovf_seen  = 0;
				ovf_exp   = 0;
			end
			"E": begin
				repeat (4) @(posedge clk_rd);
				checks++;
				if (ovf_seen != ovf_exp) begin
					note_error($sformatf("mismatch at %0d ns: %0d overflow pulses, expected %0d",
						$time, ovf_seen, ovf_exp));
				end
				tests++;
				$display("test %0d finished with %0d errors", test_id, test_errs);
			end
			"W": begin
				apb_access(1'b1, a[3:0], b, rsp);
				compare_resp(rsp, ok_rsp);
				model_write(a[3:0], b);
			end
			"R": begin
				apb_access(1'b0, a[3:0], '0, rsp);
				compare_resp(rsp, ok_rsp);
				compare_reg(rsp.prdata, b, a[3:0]);
			end
			"G": begin
				apb_access(1'b0, ADDR_GROUPS, '0, rsp);
				compare_resp(rsp, ok_rsp);
				compare_reg(rsp.prdata, 32'(model_groups), ADDR_GROUPS);
			end
			"X": begin
				apb_access(1'b0, a[3:0], '0, rsp);
				compare_resp(rsp, err_rsp);
			end
			"P": begin
				repeat (c) begin
					drive_word(int'(a), int'(b));
					model_accept(int'(a), int'(b));
				end
			end
			"O": begin
				// this word meets a full FIFO and never reaches the model
				drive_word(int'(a), int'(b));
				ovf_exp++;
			end
			"D": wait_drain();
			default: note_error($sformatf("unknown trace line: %s", line));
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// monitors and run control
	////////////////////////////////////////////////////////////

	// outputs are sampled mid cycle where they are settled
	always @(negedge clk_rd) begin
		if (!aclr_rd) begin
			if (wr_overflow) begin
				ovf_seen++;
			end
			if (rd_num_valid != '0) begin
				if (exp_groups.size() == 0) begin
					note_error($sformatf("a group of %0d lanes came out with none expected at %0d ns",
						rd_num_valid, $time));
				end else begin
					compare_group(rd_num_valid, exp_groups.pop_front());
				end
			end
		end
	end

	always @(posedge clk_rd) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: the run went past %0d cycles", limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin : main
		bit ok;
		wr_word      = '0;
		apb_req      = '0;
		pend         = 0;
		owed         = 0;
		gmax         = 8;
		model_groups = 0;
		limit        = 0;
		checks       = 0;
		errors       = 0;
		tests        = 0;
		load_trace(ok);
		if (!ok) begin
			note_error("could not open the trace file verif/rsched_trace.txt");
		end else begin
			limit = lines.size() * 40 + 200;
			@(negedge aclr_rd);
			foreach (lines[i]) begin
				run_line(lines[i]);
			end
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- verif/rsched_props.sv
////////////////////////////////////////////////////////////
// port level assertions for the regroup scheduler top
////////////////////////////////////////////////////////////

module rsched_props (
	input logic                       clk_rd,
	input logic                       aclr_rd,
	input logic                       wr_overflow,
	input rsched_lane_pkg::lane_cnt_t rd_num_valid,
	input rsched_csr_pkg::apb_req_t   apb_req,
	input rsched_csr_pkg::apb_rsp_t   apb_rsp
);
	timeunit 1ns;
	timeprecision 100ps;
	import rsched_lane_pkg::*;

	// a group is never wider than one upstream word
	a_group_width: assert property (
		@(posedge clk_rd) disable iff (aclr_rd)
		rd_num_valid <= lane_cnt_t'(LANES)
	) else $error("rd_num_valid of %0d lanes is wider than a word", rd_num_valid);

	// an error response belongs to the access phase only
	a_slverr_phase: assert property (
		@(posedge clk_rd) disable iff (aclr_rd)
		apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable)
	) else $error("pslverr raised outside an APB access phase");

	// each dropped word gives a single cycle pulse
	a_ovf_pulse: assert property (
		@(posedge clk_rd) disable iff (aclr_rd)
		wr_overflow |=> !wr_overflow
	) else $error("wr_overflow stayed high for more than one cycle");

endmodule

//--- verif/rsched_clkgen.sv
////////////////////////////////////////////////////////////
// testbench clock and reset source
////////////////////////////////////////////////////////////

module rsched_clkgen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 16
) (
	output logic clk_rd,
	output logic aclr_rd
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_rd = 1'b0;
		forever #(PERIOD_NS / 2) clk_rd = ~clk_rd;
	end

	// reset is released just after a rising edge so it never races the clock
	initial begin
		aclr_rd = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_rd);
		#1;
		aclr_rd = 1'b0;
	end

endmodule

//--- rtl/rsched_top.sv
////////////////////////////////////////////////////////////
// read regroup scheduler top level
// input FIFO, regrouper and APB register block on one clock
////////////////////////////////////////////////////////////

module rsched_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                       clk_rd,
	input  logic                       aclr_rd,
	input  rsched_lane_pkg::lane_word_t wr_word,
	output logic                       wr_overflow,
	output rsched_lane_pkg::lane_cnt_t  rd_num_valid,
	input  rsched_csr_pkg::apb_req_t    apb_req,
	output rsched_csr_pkg::apb_rsp_t    apb_rsp
);
	import rsched_lane_pkg::*;
	import rsched_csr_pkg::*;

	// FIFO head presented to the regrouper
	lane_word_t fifo_head;
	logic       fifo_not_empty;
	logic [7:0] fifo_level;

	// handshake and control between the blocks
	logic       take;
	logic       group_done;
	sched_cfg_t cfg;

	////////////////////////////////////////////////////////////
	// input buffer
	////////////////////////////////////////////////////////////

	// the drop pulse doubles as the external overflow indication
	rsched_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.clk_rd    (clk_rd),
		.aclr_rd   (aclr_rd),
		.push_word (wr_word),
		.pop       (take),
		.head      (fifo_head),
		.not_empty (fifo_not_empty),
		.level     (fifo_level),
		.dropped   (wr_overflow)
	);

	////////////////////////////////////////////////////////////
	// regrouper and registers
	////////////////////////////////////////////////////////////

	rsched_regroup i_regroup (
		.clk_rd       (clk_rd),
		.aclr_rd      (aclr_rd),
		.head         (fifo_head),
		.not_empty    (fifo_not_empty),
		.cfg          (cfg),
		.take         (take),
		.rd_num_valid (rd_num_valid),
		.group_done   (group_done)
	);

	rsched_csr i_csr (
		.clk_rd     (clk_rd),
		.aclr_rd    (aclr_rd),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.cfg        (cfg),
		.dropped    (wr_overflow),
		.level      (fifo_level),
		.group_done (group_done)
	);

endmodule

//--- rtl/rsched_csr.sv
////////////////////////////////////////////////////////////
// APB register block for the regroup scheduler
// control, sticky overflow status and the emitted group count
////////////////////////////////////////////////////////////

module rsched_csr (
	input  logic                      clk_rd,
	input  logic                      aclr_rd,
	input  rsched_csr_pkg::apb_req_t   apb_req,
	output rsched_csr_pkg::apb_rsp_t   apb_rsp,
	output rsched_csr_pkg::sched_cfg_t cfg,
	input  logic                      dropped,
	input  logic [7:0]                level,
	input  logic                      group_done
);
	import rsched_lane_pkg::*;
	import rsched_csr_pkg::*;

	logic              acc;
	logic              wr_en;
	logic              rd_en;
	logic              hit_ctrl;
	logic              hit_status;
	logic              hit_groups;
	logic              mapped;
	lane_cnt_t         gmax_wr;
	lane_cnt_t         gmax_fix;
	logic              ovf_q;
	logic [31:0]       groups_q;
	logic [APB_DW-1:0] rd_data;

	// zero wait states, every access completes in its access phase
	assign acc        = apb_req.psel && apb_req.penable;
	assign wr_en      = acc && apb_req.pwrite;
	assign rd_en      = acc && !apb_req.pwrite;
	assign hit_ctrl   = (apb_req.paddr == ADDR_CTRL);
	assign hit_status = (apb_req.paddr == ADDR_STATUS);
	assign hit_groups = (apb_req.paddr == ADDR_GROUPS);
	assign mapped     = hit_ctrl || hit_status || hit_groups;

	// group_max is held inside 1 to 8 whatever software writes
	assign gmax_wr  = apb_req.pwdata[CTRL_GMAX_LSB +: LANE_CNT_W];
	assign gmax_fix = (gmax_wr == '0) ? lane_cnt_t'(1) :
		(gmax_wr > lane_cnt_t'(LANES)) ? lane_cnt_t'(LANES) : gmax_wr;

	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			cfg.enable    <= 1'b0;
			cfg.group_max <= GMAX_RST;
			ovf_q         <= 1'b0;
			groups_q      <= '0;
		end else begin
			if (wr_en && hit_ctrl) begin
				cfg.enable    <= apb_req.pwdata[CTRL_EN_BIT];
				cfg.group_max <= gmax_fix;
			end
			// a new drop in the same cycle as the clear keeps the flag set
			if (dropped) begin
				ovf_q <= 1'b1;
			end else if (wr_en && hit_status && apb_req.pwdata[STAT_OVF_BIT]) begin
				ovf_q <= 1'b0;
			end
			// any write clears the counter and wins over a counted group
			if (wr_en && hit_groups) begin
				groups_q <= '0;
			end else if (group_done) begin
				groups_q <= groups_q + 32'd1;
			end
		end
	end

	// read data is returned from the live registers in the access phase
	always_comb begin
		rd_data = '0;
		if (rd_en && hit_ctrl) begin
			rd_data[CTRL_EN_BIT] = cfg.enable;
			rd_data[CTRL_GMAX_LSB +: LANE_CNT_W] = cfg.group_max;
		end else if (rd_en && hit_status) begin
			rd_data[STAT_OVF_BIT] = ovf_q;
			rd_data[STAT_LEVEL_LSB +: STAT_LEVEL_W] = level;
		end else if (rd_en && hit_groups) begin
			rd_data = groups_q;
		end
	end

	assign apb_rsp.prdata  = rd_data;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = acc && !mapped;

endmodule

//--- rtl/rsched_regroup.sv
////////////////////////////////////////////////////////////
// regroup scheduler
// packs incoming lanes into groups of up to group_max lanes
// and cuts a group short at every end of packet
////////////////////////////////////////////////////////////

module rsched_regroup (
	input  logic                       clk_rd,
	input  logic                       aclr_rd,
	input  rsched_lane_pkg::lane_word_t head,
	input  logic                       not_empty,
	input  rsched_csr_pkg::sched_cfg_t  cfg,
	output logic                       take,
	output rsched_lane_pkg::lane_cnt_t  rd_num_valid,
	output logic                       group_done
);
	import rsched_lane_pkg::*;

	// pend holds lanes not yet forming a full group
	// owed holds lanes that must leave because a packet ended
	acc_cnt_t  pend_q;
	acc_cnt_t  owed_q;
	acc_cnt_t  pend_d;
	acc_cnt_t  owed_d;
	acc_cnt_t  gmax;
	acc_cnt_t  hd_nv;
	acc_cnt_t  hd_eop;
	acc_cnt_t  grp_acc;
	lane_cnt_t grp_size;

	assign gmax   = acc_cnt_t'(cfg.group_max);
	assign hd_nv  = acc_cnt_t'(head.num_valid);
	assign hd_eop = acc_cnt_t'(head.eop_position);

	// a new word is only pulled in when nothing is waiting to be flushed and
	// the held lanes cannot yet make a full group
	// clearing enable stops intake but the emit path below keeps draining
	assign take = cfg.enable && not_empty && (owed_q == '0) && (pend_q < gmax);

	////////////////////////////////////////////////////////////
	// emit and accept decision
	////////////////////////////////////////////////////////////

	always_comb begin
		pend_d  = pend_q;
		owed_d  = owed_q;
		grp_acc = '0;
		if (owed_q != '0) begin
			// flush lanes go first so no group spans two packets
			grp_acc = (owed_q < gmax) ? owed_q : gmax;
			owed_d  = owed_q - grp_acc;
		end else if (pend_q >= gmax) begin
			// enough held lanes for a full group
			grp_acc = gmax;
			pend_d  = pend_q - gmax;
		end else if (take) begin
			// take implies owed is zero and pend is short of a group,
			// so accepting never coincides with an emitted group
			if (hd_eop != '0) begin
				// everything up to the end of packet becomes owed
				// and the lanes after it start the next packet
				owed_d = pend_q + hd_eop;
				pend_d = hd_nv - hd_eop;
			end else begin
				pend_d = pend_q + hd_nv;
			end
		end
	end

	// a group never exceeds group_max so it always fits a lane count
	assign grp_size = lane_cnt_t'(grp_acc);

	////////////////////////////////////////////////////////////
	// state and registered output
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			pend_q       <= '0;
			owed_q       <= '0;
			rd_num_valid <= '0;
		end else begin
			pend_q       <= pend_d;
			owed_q       <= owed_d;
			// the group size leaves on the clock after the decision
			rd_num_valid <= grp_size;
		end
	end

	// every nonzero output cycle is exactly one emitted group
	assign group_done = (rd_num_valid != '0);

endmodule

//--- rtl/rsched_fifo.sv
////////////////////////////////////////////////////////////
// show-ahead input FIFO for lane words
// drops words on full and reports its fill level
////////////////////////////////////////////////////////////

module rsched_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                       clk_rd,
	input  logic                       aclr_rd,
	input  rsched_lane_pkg::lane_word_t push_word,
	input  logic                       pop,
	output rsched_lane_pkg::lane_word_t head,
	output logic                       not_empty,
	output logic [7:0]                 level,
	output logic                       dropped
);
	import rsched_lane_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] FULL_CNT = FIFO_DEPTH[AW:0];

	lane_word_t    mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          has_word;
	logic          full;
	logic          push;
	logic          pop_ok;

	// a word with no valid lanes is an idle cycle and never occupies an entry
	assign has_word  = (push_word.num_valid != '0);
	assign full      = (count == FULL_CNT);
	assign push      = has_word && !full;
	assign pop_ok    = pop && not_empty;
	assign not_empty = (count != '0);

	// show-ahead, the oldest entry is always presented on head
	assign head  = mem[rd_ptr];
	assign level = 8'(count);

	always_ff @(posedge clk_rd) begin
		if (push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			dropped <= 1'b0;
		end else begin
			// depth is a power of two so the pointers wrap on their own
			if (push) begin
				wr_ptr <= wr_ptr + AW'(1);
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + AW'(1);
			end
			case ({push, pop_ok})
				2'b10:   count <= count + (AW+1)'(1);
				2'b01:   count <= count - (AW+1)'(1);
				default: count <= count;
			endcase
			// one cycle pulse for every word lost to a full buffer
			dropped <= has_word && full;
		end
	end

endmodule

//--- rtl/rsched_csr_pkg.sv
////////////////////////////////////////////////////////////
// read regroup scheduler register map and APB types
////////////////////////////////////////////////////////////

package rsched_csr_pkg;

	localparam int APB_AW = 4;
	localparam int APB_DW = 32;

	// register offsets inside the 16 byte window
	localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h4;
	localparam logic [APB_AW-1:0] ADDR_GROUPS = 4'h8;

	// field positions in CTRL and STATUS
	localparam int CTRL_EN_BIT    = 0;
	localparam int CTRL_GMAX_LSB  = 4;
	localparam int STAT_OVF_BIT   = 0;
	localparam int STAT_LEVEL_LSB = 8;
	localparam int STAT_LEVEL_W   = 8;

	// group_max comes out of reset at a full word
	localparam rsched_lane_pkg::lane_cnt_t GMAX_RST = 4'd8;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// control handed from the register block to the regrouper
	typedef struct packed {
		logic                      enable;
		rsched_lane_pkg::lane_cnt_t group_max;
	} sched_cfg_t;

endpackage

//--- rtl/rsched_lane_pkg.sv
////////////////////////////////////////////////////////////
// read regroup scheduler lane word definitions
// lane counts, accumulator widths and the upstream word format
////////////////////////////////////////////////////////////

package rsched_lane_pkg;

	// number of lanes carried by one upstream word
	localparam int LANES = 8;

	// a lane count holds 0 to 8, so four bits are enough
	localparam int LANE_CNT_W = 4;

	// the regrouper accumulates up to 7 held lanes plus one full word
	localparam int ACC_W = 5;

	// zero means no lanes, 1 to 8 are lane counts
	typedef logic [LANE_CNT_W-1:0] lane_cnt_t;

	// wider count used for the pending and owed lane totals
	typedef logic [ACC_W-1:0] acc_cnt_t;

	// one upstream word as seen by the FIFO and the regrouper
	// eop_position 0 means the packet does not end in this word
	// a value k means the packet ends after lane k, counting from the msb lane
	typedef struct packed {
		lane_cnt_t num_valid;
		lane_cnt_t eop_position;
	} lane_word_t;

endpackage
